/* logic/exu_defines.svh */
/*
 * Sizing macros for the execution unit.
 * Included by the package and by every module that sizes ports.
 */
`ifndef EXU_DEFINES_SVH
`define EXU_DEFINES_SVH

// datapath and register file
`define EXU_XLEN         16
`define EXU_RFIDX_WIDTH  3

// outstanding instruction tracking
`define EXU_OITF_DEPTH   4
`define EXU_ITAG_WIDTH   2

// long units
`define EXU_DMEM_DEPTH   16
`define EXU_MUL_CYCLES   16

`endif

/* logic/exu_pkg.sv */
/*
 * Types shared by the execution unit blocks.
 * Modules pull this in with a wildcard import in their header.
 */
`include "exu_defines.svh"

package exu_pkg;

    typedef enum logic [1:0] {
        OP_LI  = 2'd0,
        OP_MUL = 2'd1,
        OP_LD  = 2'd2,
        OP_ST  = 2'd3
    } exu_op_e;

    // 8-bit payload, immediate for li, register view for long ops
    typedef union packed {
        logic [7:0] imm;
        struct packed {
            logic [`EXU_RFIDX_WIDTH-1:0] rs1;
            logic [`EXU_RFIDX_WIDTH-1:0] rs2;
            logic [1:0]                  ofs;
        } regs;
    } exu_payload_u;

    typedef struct packed {
        exu_op_e                     op;
        logic [`EXU_RFIDX_WIDTH-1:0] rd;
        exu_payload_u                payload;
    } exu_instr_t;

    // dispatch to long unit
    typedef struct packed {
        logic                        valid;
        logic [`EXU_ITAG_WIDTH-1:0]  itag;
        exu_op_e                     op;
        logic [`EXU_RFIDX_WIDTH-1:0] rd;
        logic                        rdwen;
        logic [`EXU_XLEN-1:0]        rs1_val;
        logic [`EXU_XLEN-1:0]        rs2_val;
        logic [1:0]                  ofs;
    } exu_lreq_t;

    // long unit result, held until granted
    typedef struct packed {
        logic                        valid;
        logic [`EXU_ITAG_WIDTH-1:0]  itag;
        logic                        rdwen;
        logic [`EXU_RFIDX_WIDTH-1:0] rd;
        logic [`EXU_XLEN-1:0]        data;
    } exu_lrsp_t;

    typedef struct packed {
        logic                        strobe;
        logic [`EXU_RFIDX_WIDTH-1:0] rd;
        logic [`EXU_XLEN-1:0]        data;
    } exu_wb_t;

endpackage

/* logic/exu_oitf.sv */
/*
 * Outstanding instruction track FIFO.
 * One entry per dispatched long-pipe op, freed in order on retire.
 * Flags dispatch operands that still wait on an outstanding write.
 */
`timescale 1ns/1ps
`include "exu_defines.svh"

module exu_oitf (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        disp_ena,
    input  logic                        ret_ena,
    input  logic                        disp_i_rs1en,
    input  logic                        disp_i_rs2en,
    input  logic                        disp_i_rdwen,
    input  logic [`EXU_RFIDX_WIDTH-1:0] disp_i_rs1idx,
    input  logic [`EXU_RFIDX_WIDTH-1:0] disp_i_rs2idx,
    input  logic [`EXU_RFIDX_WIDTH-1:0] disp_i_rdidx,
    output logic                        disp_ready,
    output logic [`EXU_ITAG_WIDTH-1:0]  dis_ptr,
    output logic [`EXU_ITAG_WIDTH-1:0]  ret_ptr,
    output logic [`EXU_RFIDX_WIDTH-1:0] ret_rdidx,
    output logic                        ret_rdwen,
    output logic                        oitfrd_match_disprs1,
    output logic                        oitfrd_match_disprs2,
    output logic                        oitfrd_match_disprd,
    output logic                        oitf_empty
);

    // pointers carry a wrap flag in the top bit
    logic [`EXU_ITAG_WIDTH:0]    alc_ptr_r;
    logic [`EXU_ITAG_WIDTH:0]    ret_ptr_r;
    logic                        oitf_full;
    logic [`EXU_OITF_DEPTH-1:0]  vld_set;
    logic [`EXU_OITF_DEPTH-1:0]  vld_clr;
    logic [`EXU_OITF_DEPTH-1:0]  vld_r;
    logic [`EXU_OITF_DEPTH-1:0]  rdwen_r;
    logic [`EXU_RFIDX_WIDTH-1:0] rdidx_r [`EXU_OITF_DEPTH];
    logic [`EXU_OITF_DEPTH-1:0]  rs1_hit;
    logic [`EXU_OITF_DEPTH-1:0]  rs2_hit;
    logic [`EXU_OITF_DEPTH-1:0]  rd_hit;

    // ======================================================================
    // pointers and occupancy
    // ======================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            alc_ptr_r <= '0;
            ret_ptr_r <= '0;
        end else begin
            if (disp_ena) begin
                alc_ptr_r <= alc_ptr_r + 1'b1;
            end
            if (ret_ena) begin
                ret_ptr_r <= ret_ptr_r + 1'b1;
            end
        end
    end

    assign dis_ptr    = alc_ptr_r[`EXU_ITAG_WIDTH-1:0];
    assign ret_ptr    = ret_ptr_r[`EXU_ITAG_WIDTH-1:0];
    assign oitf_empty = (alc_ptr_r == ret_ptr_r);
    assign oitf_full  = (dis_ptr == ret_ptr)
                      & (alc_ptr_r[`EXU_ITAG_WIDTH] != ret_ptr_r[`EXU_ITAG_WIDTH]);
    // a retire in the same cycle does not free a slot early
    assign disp_ready = ~oitf_full;

    // ======================================================================
    // entries
    // ======================================================================
    assign vld_set = `EXU_OITF_DEPTH'(disp_ena) << dis_ptr;
    assign vld_clr = `EXU_OITF_DEPTH'(ret_ena) << ret_ptr;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            vld_r <= '0;
        end else begin
            vld_r <= (vld_r | vld_set) & ~vld_clr;
        end
    end

    always_ff @(posedge clk) begin
        if (disp_ena) begin
            rdidx_r[dis_ptr] <= disp_i_rdidx;
            rdwen_r[dis_ptr] <= disp_i_rdwen;
        end
    end

    // hazard match against every live writing entry
    always_comb begin
        for (int i = 0; i < `EXU_OITF_DEPTH; i++) begin
            rs1_hit[i] = vld_r[i] & rdwen_r[i] & disp_i_rs1en & (rdidx_r[i] == disp_i_rs1idx);
            rs2_hit[i] = vld_r[i] & rdwen_r[i] & disp_i_rs2en & (rdidx_r[i] == disp_i_rs2idx);
            rd_hit[i]  = vld_r[i] & rdwen_r[i] & disp_i_rdwen & (rdidx_r[i] == disp_i_rdidx);
        end
    end

    assign oitfrd_match_disprs1 = |rs1_hit;
    assign oitfrd_match_disprs2 = |rs2_hit;
    assign oitfrd_match_disprd  = |rd_hit;

    // info for the entry at the retire pointer
    assign ret_rdidx = rdidx_r[ret_ptr];
    assign ret_rdwen = rdwen_r[ret_ptr];

endmodule

/* logic/exu_disp.sv */
/*
 * Dispatch stage. Decodes one instruction word per cycle, checks
 * the stall rules and sends it to the short path or a long unit.
 */
`timescale 1ns/1ps
`include "exu_defines.svh"

module exu_disp import exu_pkg::*; (
    input  logic                        clk,
    input  logic                        rst_n,
    input  exu_instr_t                  instr,
    input  logic                        instr_valid,
    input  logic                        oitfrd_match_disprs1,
    input  logic                        oitfrd_match_disprs2,
    input  logic                        oitfrd_match_disprd,
    input  logic                        disp_ready,
    input  logic [`EXU_ITAG_WIDTH-1:0]  dis_ptr,
    input  logic [`EXU_XLEN-1:0]        rs1_data,
    input  logic [`EXU_XLEN-1:0]        rs2_data,
    input  logic                        mul_busy,
    input  logic                        lsu_busy,
    input  logic                        lwb_active,
    output logic                        instr_ready,
    output logic                        disp_ena,
    output logic                        disp_i_rs1en,
    output logic                        disp_i_rs2en,
    output logic                        disp_i_rdwen,
    output logic [`EXU_RFIDX_WIDTH-1:0] disp_i_rs1idx,
    output logic [`EXU_RFIDX_WIDTH-1:0] disp_i_rs2idx,
    output logic [`EXU_RFIDX_WIDTH-1:0] disp_i_rdidx,
    output logic [`EXU_RFIDX_WIDTH-1:0] rs1_idx,
    output logic [`EXU_RFIDX_WIDTH-1:0] rs2_idx,
    output exu_wb_t                     li_wb,
    output exu_lreq_t                   mul_req,
    output exu_lreq_t                   lsu_req
);

    logic      is_li;
    logic      is_mul;
    logic      is_st;
    logic      hazard;
    logic      unit_busy;
    logic      fire;
    logic      run_r;
    exu_lreq_t lreq;

    assign is_li  = (instr.op == OP_LI);
    assign is_mul = (instr.op == OP_MUL);
    assign is_st  = (instr.op == OP_ST);

    // operand enables per op
    assign disp_i_rs1en  = ~is_li;
    assign disp_i_rs2en  = is_mul | is_st;
    assign disp_i_rdwen  = ~is_st;
    assign disp_i_rs1idx = instr.payload.regs.rs1;
    assign disp_i_rs2idx = instr.payload.regs.rs2;
    assign disp_i_rdidx  = instr.rd;
    assign rs1_idx       = instr.payload.regs.rs1;
    assign rs2_idx       = instr.payload.regs.rs2;

    // held low until the first edge after reset
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            run_r <= 1'b0;
        end else begin
            run_r <= 1'b1;
        end
    end

    assign hazard    = oitfrd_match_disprs1 | oitfrd_match_disprs2 | oitfrd_match_disprd;
    assign unit_busy = is_mul ? mul_busy : lsu_busy;
    // li shares the regfile write port with the long write
    assign instr_ready = run_r & ~hazard
                       & (is_li ? ~lwb_active : (disp_ready & ~unit_busy));
    assign fire     = instr_valid & instr_ready;
    assign disp_ena = fire & ~is_li;

    // li writes at the accepting edge
    assign li_wb.strobe = fire & is_li;
    assign li_wb.rd     = instr.rd;
    assign li_wb.data   = {{(`EXU_XLEN-8){1'b0}}, instr.payload.imm};

    always_comb begin
        lreq.valid   = 1'b0;
        lreq.itag    = dis_ptr;
        lreq.op      = instr.op;
        lreq.rd      = instr.rd;
        lreq.rdwen   = disp_i_rdwen;
        lreq.rs1_val = rs1_data;
        lreq.rs2_val = rs2_data;
        lreq.ofs     = instr.payload.regs.ofs;
        mul_req       = lreq;
        mul_req.valid = disp_ena & is_mul;
        lsu_req       = lreq;
        lsu_req.valid = disp_ena & ~is_mul;
    end

endmodule

/* logic/exu_mul.sv */
/*
 * Iterative shift-add multiplier, one bit of rs2 per cycle.
 * Keeps the low half of the product and holds it until granted.
 */
`timescale 1ns/1ps
`include "exu_defines.svh"

module exu_mul import exu_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  exu_lreq_t req,
    input  logic      grant,
    output logic      busy,
    output exu_lrsp_t rsp
);

    localparam int CW = $clog2(`EXU_MUL_CYCLES);

    logic                 run_r;
    logic [CW-1:0]        cnt_r;
    logic [`EXU_XLEN-1:0] mcand_r;
    logic [`EXU_XLEN-1:0] mplier_r;
    exu_lrsp_t            rsp_r;

    // rsp_r.data doubles as the accumulator
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            run_r <= 1'b0;
            cnt_r <= '0;
            rsp_r <= '0;
        end else if (req.valid) begin
            run_r       <= 1'b1;
            cnt_r       <= '0;
            rsp_r.itag  <= req.itag;
            rsp_r.rdwen <= req.rdwen;
            rsp_r.rd    <= req.rd;
            rsp_r.data  <= '0;
        end else if (run_r) begin
            if (mplier_r[0]) begin
                rsp_r.data <= rsp_r.data + mcand_r;
            end
            cnt_r <= cnt_r + 1'b1;
            // last iteration raises the response
            if (cnt_r == CW'(`EXU_MUL_CYCLES - 1)) begin
                run_r       <= 1'b0;
                rsp_r.valid <= 1'b1;
            end
        end else if (grant) begin
            rsp_r.valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (req.valid) begin
            mcand_r  <= req.rs1_val;
            mplier_r <= req.rs2_val;
        end else if (run_r) begin
            mcand_r  <= mcand_r << 1;
            mplier_r <= mplier_r >> 1;
        end
    end

    assign busy = run_r | rsp_r.valid;
    assign rsp  = rsp_r;

endmodule

/* logic/exu_lsu.sv */
/*
 * Load/store unit over a small data memory.
 * Stage one accesses memory, stage two holds the response until
 * granted and stalls stage one while it waits.
 */
`timescale 1ns/1ps
`include "exu_defines.svh"

module exu_lsu import exu_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  exu_lreq_t req,
    input  logic      grant,
    output logic      busy,
    output exu_lrsp_t rsp
);

    localparam int AW = $clog2(`EXU_DMEM_DEPTH);

    logic [`EXU_XLEN-1:0] dmem [`EXU_DMEM_DEPTH];
    logic [`EXU_XLEN-1:0] sum;
    logic [AW-1:0]        addr;
    logic                 s2_ld;
    exu_lrsp_t            s1_r;
    exu_lrsp_t            rsp_r;

    assign sum  = req.rs1_val + `EXU_XLEN'(req.ofs);
    assign addr = sum[AW-1:0];

    // stage two takes stage one unless a response is still held
    assign s2_ld = s1_r.valid & (~rsp_r.valid | grant);
    assign busy  = s1_r.valid & rsp_r.valid & ~grant;

    // ======================================================================
    // data memory, zero after reset
    // ======================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `EXU_DMEM_DEPTH; i++) begin
                dmem[i] <= '0;
            end
        end else if (req.valid && req.op == OP_ST) begin
            dmem[addr] <= req.rs2_val;
        end
    end

    // ======================================================================
    // pipeline registers
    // ======================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s1_r  <= '0;
            rsp_r <= '0;
        end else begin
            if (req.valid) begin
                s1_r.valid <= 1'b1;
                s1_r.itag  <= req.itag;
                s1_r.rdwen <= req.rdwen;
                s1_r.rd    <= req.rd;
                s1_r.data  <= dmem[addr];
            end else if (s2_ld) begin
                s1_r.valid <= 1'b0;
            end
            if (s2_ld) begin
                rsp_r <= s1_r;
            end else if (grant) begin
                rsp_r.valid <= 1'b0;
            end
        end
    end

    assign rsp = rsp_r;

endmodule

/* logic/exu_longpwb.sv */
/*
 * Long-pipe write-back arbiter. Only the unit whose tag is the OITF
 * retire tag is granted, so long ops retire in program order.
 */
`timescale 1ns/1ps
`include "exu_defines.svh"

module exu_longpwb import exu_pkg::*; (
    input  exu_lrsp_t                   mul_rsp,
    input  exu_lrsp_t                   lsu_rsp,
    input  logic [`EXU_ITAG_WIDTH-1:0]  ret_ptr,
    input  logic [`EXU_RFIDX_WIDTH-1:0] ret_rdidx,
    input  logic                        ret_rdwen,
    output logic                        mul_grant,
    output logic                        lsu_grant,
    output logic                        ret_ena,
    output exu_wb_t                     lwb,
    output logic                        lwb_active
);

    // at most one unit holds the retire tag
    assign mul_grant = mul_rsp.valid & (mul_rsp.itag == ret_ptr);
    assign lsu_grant = lsu_rsp.valid & (lsu_rsp.itag == ret_ptr);
    assign ret_ena   = mul_grant | lsu_grant;

    // stores retire here too, without a write
    assign lwb.strobe = ret_ena & ret_rdwen;
    assign lwb.rd     = ret_rdidx;
    assign lwb.data   = mul_grant ? mul_rsp.data : lsu_rsp.data;
    assign lwb_active = lwb.strobe;

endmodule

/* logic/exu_regfile.sv */
/*
 * Eight-entry register file, two read ports and one write port.
 * The long write wins the port; wb reports each write a cycle later.
 */
`timescale 1ns/1ps
`include "exu_defines.svh"

module exu_regfile import exu_pkg::*; (
    input  logic                        clk,
    input  logic                        rst_n,
    input  exu_wb_t                     li_wb,
    input  exu_wb_t                     lwb,
    input  logic [`EXU_RFIDX_WIDTH-1:0] rs1_idx,
    input  logic [`EXU_RFIDX_WIDTH-1:0] rs2_idx,
    output logic [`EXU_XLEN-1:0]        rs1_data,
    output logic [`EXU_XLEN-1:0]        rs2_data,
    output exu_wb_t                     wb
);

    logic [`EXU_XLEN-1:0] regs [1 << `EXU_RFIDX_WIDTH];
    exu_wb_t              wr;

    assign wr = lwb.strobe ? lwb : li_wb;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < (1 << `EXU_RFIDX_WIDTH); i++) begin
                regs[i] <= '0;
            end
            wb <= '0;
        end else begin
            if (wr.strobe) begin
                regs[wr.rd] <= wr.data;
            end
            wb <= wr;
        end
    end

    assign rs1_data = regs[rs1_idx];
    assign rs2_data = regs[rs2_idx];

endmodule

/* logic/exu_top.sv */
/*
 * Execution unit top. Dispatch, OITF, multiplier, load/store unit,
 * write-back arbiter and register file wired together.
 */
`timescale 1ns/1ps
`include "exu_defines.svh"

module exu_top import exu_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  exu_instr_t instr,
    input  logic       instr_valid,
    output logic       instr_ready,
    output exu_wb_t    wb,
    output logic       oitf_empty
);

    // dispatch to OITF
    logic                        disp_ena;
    logic                        disp_i_rs1en;
    logic                        disp_i_rs2en;
    logic                        disp_i_rdwen;
    logic [`EXU_RFIDX_WIDTH-1:0] disp_i_rs1idx;
    logic [`EXU_RFIDX_WIDTH-1:0] disp_i_rs2idx;
    logic [`EXU_RFIDX_WIDTH-1:0] disp_i_rdidx;
    logic                        disp_ready;
    logic [`EXU_ITAG_WIDTH-1:0]  dis_ptr;
    logic                        match_rs1;
    logic                        match_rs2;
    logic                        match_rd;

    // retire side
    logic [`EXU_ITAG_WIDTH-1:0]  ret_ptr;
    logic [`EXU_RFIDX_WIDTH-1:0] ret_rdidx;
    logic                        ret_rdwen;
    logic                        ret_ena;

    // register file
    logic [`EXU_RFIDX_WIDTH-1:0] rs1_idx;
    logic [`EXU_RFIDX_WIDTH-1:0] rs2_idx;
    logic [`EXU_XLEN-1:0]        rs1_data;
    logic [`EXU_XLEN-1:0]        rs2_data;
    exu_wb_t                     li_wb;
    exu_wb_t                     lwb;
    logic                        lwb_active;

    // long units
    exu_lreq_t                   mul_req;
    exu_lreq_t                   lsu_req;
    exu_lrsp_t                   mul_rsp;
    exu_lrsp_t                   lsu_rsp;
    logic                        mul_busy;
    logic                        lsu_busy;
    logic                        mul_grant;
    logic                        lsu_grant;

    exu_disp u_disp (
        .clk                  (clk),
        .rst_n                (rst_n),
        .instr                (instr),
        .instr_valid          (instr_valid),
        .oitfrd_match_disprs1 (match_rs1),
        .oitfrd_match_disprs2 (match_rs2),
        .oitfrd_match_disprd  (match_rd),
        .disp_ready           (disp_ready),
        .dis_ptr              (dis_ptr),
        .rs1_data             (rs1_data),
        .rs2_data             (rs2_data),
        .mul_busy             (mul_busy),
        .lsu_busy             (lsu_busy),
        .lwb_active           (lwb_active),
        .instr_ready          (instr_ready),
        .disp_ena             (disp_ena),
        .disp_i_rs1en         (disp_i_rs1en),
        .disp_i_rs2en         (disp_i_rs2en),
        .disp_i_rdwen         (disp_i_rdwen),
        .disp_i_rs1idx        (disp_i_rs1idx),
        .disp_i_rs2idx        (disp_i_rs2idx),
        .disp_i_rdidx         (disp_i_rdidx),
        .rs1_idx              (rs1_idx),
        .rs2_idx              (rs2_idx),
        .li_wb                (li_wb),
        .mul_req              (mul_req),
        .lsu_req              (lsu_req)
    );

    exu_oitf u_oitf (
        .clk                  (clk),
        .rst_n                (rst_n),
        .disp_ena             (disp_ena),
        .ret_ena              (ret_ena),
        .disp_i_rs1en         (disp_i_rs1en),
        .disp_i_rs2en         (disp_i_rs2en),
        .disp_i_rdwen         (disp_i_rdwen),
        .disp_i_rs1idx        (disp_i_rs1idx),
        .disp_i_rs2idx        (disp_i_rs2idx),
        .disp_i_rdidx         (disp_i_rdidx),
        .disp_ready           (disp_ready),
        .dis_ptr              (dis_ptr),
        .ret_ptr              (ret_ptr),
        .ret_rdidx            (ret_rdidx),
        .ret_rdwen            (ret_rdwen),
        .oitfrd_match_disprs1 (match_rs1),
        .oitfrd_match_disprs2 (match_rs2),
        .oitfrd_match_disprd  (match_rd),
        .oitf_empty           (oitf_empty)
    );

    exu_mul u_mul (
        .clk   (clk),
        .rst_n (rst_n),
        .req   (mul_req),
        .grant (mul_grant),
        .busy  (mul_busy),
        .rsp   (mul_rsp)
    );

    exu_lsu u_lsu (
        .clk   (clk),
        .rst_n (rst_n),
        .req   (lsu_req),
        .grant (lsu_grant),
        .busy  (lsu_busy),
        .rsp   (lsu_rsp)
    );

    exu_longpwb u_longpwb (
        .mul_rsp    (mul_rsp),
        .lsu_rsp    (lsu_rsp),
        .ret_ptr    (ret_ptr),
        .ret_rdidx  (ret_rdidx),
        .ret_rdwen  (ret_rdwen),
        .mul_grant  (mul_grant),
        .lsu_grant  (lsu_grant),
        .ret_ena    (ret_ena),
        .lwb        (lwb),
        .lwb_active (lwb_active)
    );

    exu_regfile u_regfile (
        .clk      (clk),
        .rst_n    (rst_n),
        .li_wb    (li_wb),
        .lwb      (lwb),
        .rs1_idx  (rs1_idx),
        .rs2_idx  (rs2_idx),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .wb       (wb)
    );

endmodule

/* dv/exu_checker.sv */
/*
 * Reference checker for the execution unit. Snoops accepted words,
 * models registers and memory in program order, and matches every
 * wb write against the oldest expected write to the same register.
 */
`timescale 1ns/1ps
`include "exu_defines.svh"

module exu_checker import exu_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  exu_instr_t instr,
    input  logic       instr_valid,
    input  logic       instr_ready,
    input  exu_wb_t    wb,
    input  logic       oitf_empty,
    input  logic       drained,
    input  logic       end_chk,
    output int         data_errs,
    output int         proto_errs
);

    typedef struct packed {
        logic [`EXU_RFIDX_WIDTH-1:0] rd;
        logic [`EXU_XLEN-1:0]        data;
    } exp_wr_t;

    logic [`EXU_XLEN-1:0]        mregs [1 << `EXU_RFIDX_WIDTH];
    logic [`EXU_XLEN-1:0]        mmem [`EXU_DMEM_DEPTH];
    exp_wr_t                     exp_q [$];
    logic                        li_due;
    logic [`EXU_RFIDX_WIDTH-1:0] li_rd;

    // sequential model of one accepted instruction
    task automatic model_instr(input exu_instr_t ins);
        logic [`EXU_XLEN-1:0] a;
        logic [`EXU_XLEN-1:0] b;
        logic [`EXU_XLEN-1:0] sum;
        logic [`EXU_XLEN-1:0] res;
        logic [3:0]           addr;
        a    = mregs[ins.payload.regs.rs1];
        b    = mregs[ins.payload.regs.rs2];
        sum  = a + {{(`EXU_XLEN-2){1'b0}}, ins.payload.regs.ofs};
        addr = sum[3:0];
        res  = '0;
        case (ins.op)
            OP_LI: begin
                res    = {{(`EXU_XLEN-8){1'b0}}, ins.payload.imm};
                li_due = 1'b1;
                li_rd  = ins.rd;
            end
            OP_MUL:  res = a * b;
            OP_LD:   res = mmem[addr];
            default: mmem[addr] = b;
        endcase
        if (ins.op != OP_ST) begin
            mregs[ins.rd] = res;
            exp_q.push_back({ins.rd, res});
        end
    endtask

    // sample mid-cycle where inputs and outputs are settled
    always @(negedge clk) begin : snoop
        int idx;
        if (!rst_n) begin
            for (int i = 0; i < (1 << `EXU_RFIDX_WIDTH); i++) begin
                mregs[i] = '0;
            end
            for (int i = 0; i < `EXU_DMEM_DEPTH; i++) begin
                mmem[i] = '0;
            end
            exp_q.delete();
            li_due     = 1'b0;
            li_rd      = '0;
            data_errs  = 0;
            proto_errs = 0;
        end else begin
            // li accepted at the last edge must be on wb now
            if (li_due) begin
                if (!wb.strobe || wb.rd != li_rd) begin
                    $display("Error at %0t: wb.rd got %0d (strobe %b) expected %0d",
                             $time, wb.rd, wb.strobe, li_rd);
                    proto_errs++;
                end
                li_due = 1'b0;
            end
            if (wb.strobe) begin
                idx = -1;
                for (int i = 0; i < exp_q.size(); i++) begin
                    if (idx < 0 && exp_q[i].rd == wb.rd) begin
                        idx = i;
                    end
                end
                if (idx < 0) begin
                    if (drained) begin
                        $display("register write to r%0d at %0t after the pipeline drained",
                                 wb.rd, $time);
                    end else begin
                        $display("register write to r%0d at %0t that no instruction owes",
                                 wb.rd, $time);
                    end
                    proto_errs++;
                end else begin
                    if (wb.data !== exp_q[idx].data) begin
                        $display("Error at %0t: wb.data for r%0d got %h expected %h",
                                 $time, wb.rd, wb.data, exp_q[idx].data);
                        data_errs++;
                    end
                    exp_q.delete(idx);
                end
            end
            if (instr_valid && instr_ready) begin
                model_instr(instr);
            end
            if (end_chk) begin
                if (exp_q.size() != 0) begin
                    $display("%0d expected register writes never appeared", exp_q.size());
                    proto_errs++;
                end
                if (!oitf_empty) begin
                    $display("OITF still holds entries at the end of the run");
                    proto_errs++;
                end
            end
        end
    end

endmodule

/* dv/tb_exu.sv */
/*
 * Testbench for the execution unit. Runs a seeded random program
 * through the DUT while exu_checker models it and compares writes.
 */
`timescale 1ns/1ps
`include "exu_defines.svh"

module tb_exu import exu_pkg::*; ();

    localparam int          N_INSTR    = 2000;
    localparam int          MAX_CYCLES = N_INSTR * (`EXU_MUL_CYCLES + 4) + 100;
    localparam logic [31:0] SEED       = 32'h368a157d;
    // op mix in percent with stores taking the rest
    localparam int          W_LI       = 35;
    localparam int          W_MUL      = 15;
    localparam int          W_LD       = 25;

    logic                        clk;
    logic                        rst_n;
    exu_instr_t                  instr;
    logic                        instr_valid;
    logic                        instr_ready;
    exu_wb_t                     wb;
    logic                        oitf_empty;
    logic                        drained;
    logic                        end_chk;
    int                          data_errs;
    int                          proto_errs;
    int                          cycle_cnt;
    logic [`EXU_RFIDX_WIDTH-1:0] last_rd;

    exu_top uut (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr       (instr),
        .instr_valid (instr_valid),
        .instr_ready (instr_ready),
        .wb          (wb),
        .oitf_empty  (oitf_empty)
    );

    exu_checker u_checker (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr       (instr),
        .instr_valid (instr_valid),
        .instr_ready (instr_ready),
        .wb          (wb),
        .oitf_empty  (oitf_empty),
        .drained     (drained),
        .end_chk     (end_chk),
        .data_errs   (data_errs),
        .proto_errs  (proto_errs)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // ======================================================================
    // stimulus helpers
    // ======================================================================
    function automatic exu_instr_t make_instr(input logic in_burst);
        exu_instr_t  ins;
        logic [31:0] r;
        int          pick;
        r               = $urandom;
        pick            = $urandom % 100;
        ins.rd          = r[2:0];
        ins.payload.imm = r[15:8];
        if (in_burst) begin
            // mul and load chains that lean on the previous result
            ins.op = (pick < 50) ? OP_MUL : OP_LD;
            if (r[16]) begin
                ins.payload.regs.rs1 = last_rd;
            end
        end else if (pick < W_LI) begin
            ins.op = OP_LI;
        end else if (pick < W_LI + W_MUL) begin
            ins.op = OP_MUL;
        end else if (pick < W_LI + W_MUL + W_LD) begin
            ins.op = OP_LD;
        end else begin
            ins.op = OP_ST;
        end
        return ins;
    endfunction

    task automatic idle_cycles(input int n);
        instr_valid = 1'b0;
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    // hold the word until an edge accepts it
    task automatic send_instr(input exu_instr_t ins);
        logic taken;
        taken       = 1'b0;
        instr       = ins;
        instr_valid = 1'b1;
        while (!taken) begin
            @(negedge clk);
            taken = instr_ready;
            @(posedge clk);
            #1;
        end
        instr_valid = 1'b0;
    endtask

    // ======================================================================
    // main sequence
    // ======================================================================
    initial begin
        exu_instr_t  ins;
        int          sent;
        int          burst_left;
        int          gap;
        void'($urandom(SEED));
        rst_n       = 1'b0;
        instr       = '0;
        instr_valid = 1'b0;
        drained     = 1'b0;
        end_chk     = 1'b0;
        last_rd     = '0;
        sent        = 0;
        burst_left  = 0;
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;

        while (sent < N_INSTR) begin
            if (burst_left == 0 && $urandom % 16 == 0) begin
                burst_left = 4 + $urandom % 5;
            end
            gap = 0;
            if (burst_left == 0 && $urandom % 4 == 0) begin
                gap = 1 + $urandom % 3;
            end
            idle_cycles(gap);
            ins = make_instr(burst_left != 0);
            send_instr(ins);
            if (ins.op != OP_ST) begin
                last_rd = ins.rd;
            end
            if (burst_left > 0) begin
                burst_left--;
            end
            sent++;
        end

        // wait for the last long-pipe entry to retire
        do begin
            @(posedge clk);
            #1;
        end while (!oitf_empty);
        drained = 1'b1;
        repeat (8) begin
            @(posedge clk);
            #1;
        end
        end_chk = 1'b1;
        @(posedge clk);
        #1;
        end_chk = 1'b0;
        @(posedge clk);
        #1;

        $display("errors: %0d data, %0d protocol", data_errs, proto_errs);
        if (data_errs == 0 && proto_errs == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    // run limit sized for a program of only multiplies
    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < MAX_CYCLES) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("timeout after %0d cycles, the DUT stopped making progress", cycle_cnt);
        $display("** FAIL **");
        $finish;
    end

endmodule

/* project.f */
+incdir+logic
logic/exu_pkg.sv
logic/exu_oitf.sv
logic/exu_disp.sv
logic/exu_mul.sv
logic/exu_lsu.sv
logic/exu_longpwb.sv
logic/exu_regfile.sv
logic/exu_top.sv
dv/exu_checker.sv
dv/tb_exu.sv
